// ==== rtl/dense_settings.svh ====
// ####################
// dense layer settings
// widths, feature count and output wait length
// ####################

`ifndef DENSE_SETTINGS_SVH
`define DENSE_SETTINGS_SVH

// width of one feature and of the result
`define DENSE_DATA_WIDTH 16

// fraction bits of the fixed-point format
`define DENSE_FRAC_BITS 10

// features per input vector
`define DENSE_NUM_INPUTS 10

// ten full 32-bit products plus bias, with headroom
`define DENSE_ACC_WIDTH 36

// input refused for this many cycles after each output, 0 turns it off
`define DENSE_OUTPUT_WAIT_CYCLES 2

`endif

// ==== rtl/dense_pkg.sv ====
// ####################
// dense layer types
// fixed-point types, weights, bias and state encodings
// ####################

`default_nettype none

`include "dense_settings.svh"

package dense_pkg;

  // one signed value, 10 fraction bits
  typedef logic signed [`DENSE_DATA_WIDTH-1:0] fixed_t;

  // full input vector
  typedef fixed_t [`DENSE_NUM_INPUTS-1:0] feature_vec_t;

  // wide accumulator for products
  typedef logic signed [`DENSE_ACC_WIDTH-1:0] acc_t;

  // two half sums out of the first execute stage
  typedef acc_t [1:0] partial_vec_t;

  // ####################
  // layer constants
  // ####################

  // weights, 1.0 = 1024
  localparam fixed_t dense_weights [`DENSE_NUM_INPUTS] = '{
    16'sd1536,  -16'sd768,  16'sd3277, -16'sd2458,  16'sd410,
    -16'sd4000,  16'sd123,  16'sd2048, -16'sd1229,  16'sd3900
  };

  // bias, 0.5
  localparam fixed_t dense_bias = 16'sd512;

  // ####################
  // state encodings
  // ####################

  // output register occupancy
  typedef enum logic {OUT_EMPTY, OUT_FULL} out_state_t;

  // wait after output
  typedef enum logic {NOT_WAITING, WAITING} wait_state_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_ctrl_if.sv ====
// ####################
// pipeline link between the stages
// operands, final sum and stall control
// ####################

`default_nettype none
`timescale 1ns/10ps

interface pipe_ctrl_if import dense_pkg::*;;

  // high when every pipeline register may load
  logic advance;
  // post-output wait in progress
  logic waiting;

  // first stage contents
  logic         operand_valid;
  feature_vec_t operands;

  // truncated result of the execute stages
  logic   sum_valid;
  fixed_t sum;

  // input capture
  modport decode (input advance, input waiting, output operand_valid, output operands);

  // arithmetic
  modport execute (input advance, input operand_valid, input operands,
                   output sum_valid, output sum);

  // output register and wait counter, owns the stall
  modport result (output advance, output waiting, input sum_valid, input sum);

endinterface

`default_nettype wire

// ==== rtl/input_decode.sv ====
// ####################
// input capture stage
// handshake on the input side, first pipeline register
// ####################

`default_nettype none
`timescale 1ns/10ps

module input_decode import dense_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  input  logic         data_in_valid,
  input  feature_vec_t data_in,
  output logic         data_in_ready,

  pipe_ctrl_if.decode  pipe
);

  // vector taken on this edge
  logic accept;

  // ####################
  // handshake
  // ####################

  // ready only when the pipe moves and no wait is running
  assign data_in_ready = pipe.advance & ~pipe.waiting;
  assign accept        = data_in_valid & data_in_ready;

  // ####################
  // operand register
  // ####################

  // valid bit holds on stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe.operand_valid <= 1'b0;
    end else if (pipe.advance) begin
      // empties unless a new vector comes in
      pipe.operand_valid <= accept;
    end
  end

  // payload only written on a transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      pipe.operands <= data_in;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dense_execute.sv ====
// ####################
// dense layer arithmetic
// products and half sums, then bias, truncation and wrap
// ####################

`default_nettype none
`timescale 1ns/10ps

module dense_execute import dense_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  pipe_ctrl_if.execute pipe
);

  // features per half sum
  localparam int half_inputs = `DENSE_NUM_INPUTS / 2;

  // stage one outputs
  partial_vec_t partial_next;
  partial_vec_t partial_q;
  logic         partial_valid;

  // stage two combinational result
  fixed_t sum_next;

  // full-width signed product, 20 fraction bits
  function automatic acc_t mul_fixed(input fixed_t a, input fixed_t b);
    acc_t ext_a;
    acc_t ext_b;
    // sign extend first so the product keeps all its bits
    ext_a = a;
    ext_b = b;
    return ext_a * ext_b;
  endfunction

  // ####################
  // stage one
  // ####################

  // multiply, two half sums of five products each
  always_comb begin
    partial_next = '0;
    for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
      if (i < half_inputs) begin
        partial_next[0] = partial_next[0] + mul_fixed(pipe.operands[i], dense_weights[i]);
      end else begin
        partial_next[1] = partial_next[1] + mul_fixed(pipe.operands[i], dense_weights[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial_valid <= 1'b0;
    end else if (pipe.advance) begin
      partial_valid <= pipe.operand_valid;
    end
  end

  // half sums, no reset
  always_ff @(posedge clk) begin
    if (pipe.advance) begin
      partial_q <= partial_next;
    end
  end

  // ####################
  // stage two
  // ####################

  // add bias, drop the extra fraction bits, keep the low word
  always_comb begin
    acc_t bias_ext;
    acc_t total;
    acc_t shifted;
    bias_ext = dense_bias;
    total    = partial_q[0] + partial_q[1] + (bias_ext <<< `DENSE_FRAC_BITS);
    // arithmetic shift floors toward minus infinity
    shifted  = total >>> `DENSE_FRAC_BITS;
    // upper bits dropped, so overflow wraps
    sum_next = shifted[`DENSE_DATA_WIDTH-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe.sum_valid <= 1'b0;
    end else if (pipe.advance) begin
      pipe.sum_valid <= partial_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pipe.advance) begin
      pipe.sum <= sum_next;
    end
  end

  // ####################
  // checks
  // ####################

  // stall from the output side freezes the final sum
  a_sum_stable_on_stall : assert property (
    @(posedge clk) disable iff (!rst_n)
    !pipe.advance |=> $stable(pipe.sum) && $stable(pipe.sum_valid)
  ) else $error("execute stage sum changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/result_stage.sv ====
// ####################
// output stage
// output register, pipeline stall and post-output wait
// ####################

`default_nettype none
`timescale 1ns/10ps

`include "dense_settings.svh"

module result_stage import dense_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  output logic        data_out_valid,
  output fixed_t      data_out,
  input  logic        data_out_ready,

  pipe_ctrl_if.result pipe
);

  // wait length and counter sizing
  localparam int unsigned wait_cycles = `DENSE_OUTPUT_WAIT_CYCLES;
  localparam int unsigned wait_w      = (wait_cycles > 1) ? $clog2(wait_cycles) : 1;
  localparam logic [wait_w-1:0] wait_start = (wait_cycles > 0) ? wait_w'(wait_cycles - 1) : '0;

  out_state_t  out_state;
  wait_state_t wait_state;

  // remaining wait cycles after the current one
  logic [wait_w-1:0] wait_count;

  // result leaves on this edge
  logic out_xfer;

  // ####################
  // output register
  // ####################

  assign data_out_valid = (out_state == OUT_FULL);
  assign out_xfer       = data_out_valid & data_out_ready;

  // pipe moves when the register is empty or drains now
  assign pipe.advance = (out_state == OUT_EMPTY) | data_out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_state <= OUT_EMPTY;
    end else if (pipe.advance) begin
      // refill from the sum, else go empty after the transfer
      out_state <= pipe.sum_valid ? OUT_FULL : OUT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (pipe.advance && pipe.sum_valid) begin
      data_out <= pipe.sum;
    end
  end

  // ####################
  // wait after output
  // ####################

  assign pipe.waiting = (wait_state == WAITING);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_state <= NOT_WAITING;
      wait_count <= '0;
    end else begin
      case (wait_state)
        NOT_WAITING: begin
          if (out_xfer && wait_cycles != 0) begin
            wait_state <= WAITING;
            wait_count <= wait_start;
          end
        end
        WAITING: begin
          // another output restarts the wait
          if (out_xfer) begin
            wait_count <= wait_start;
          end else if (wait_count == '0) begin
            wait_state <= NOT_WAITING;
          end else begin
            wait_count <= wait_count - 1'b1;
          end
        end
        default: wait_state <= NOT_WAITING;
      endcase
    end
  end

  // ####################
  // checks
  // ####################

  // stalled result must not change
  a_out_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out)
  ) else $error("data_out changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/dense_layer_top.sv ====
// ####################
// dense layer top
// ten features in, one fixed-point dot product out
// ####################

`default_nettype none
`timescale 1ns/10ps

module dense_layer_top import dense_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // vector input
  input  logic         data_in_valid,
  input  feature_vec_t data_in,
  output logic         data_in_ready,

  // result output
  output logic         data_out_valid,
  output fixed_t       data_out,
  input  logic         data_out_ready
);

  // shared stage link
  pipe_ctrl_if pipe ();

  // stage 1, input capture
  input_decode u_input_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in_valid (data_in_valid),
    .data_in       (data_in),
    .data_in_ready (data_in_ready),
    .pipe          (pipe.decode)
  );

  // stages 2 and 3, arithmetic
  dense_execute u_dense_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .pipe  (pipe.execute)
  );

  // stage 4, output register and wait
  result_stage u_result_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .pipe           (pipe.result)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_dense_layer.sv ====
// ####################
// dense layer testbench
// latency, wait after output, back-pressure, wrap and reset checks
// ####################

`default_nettype none
`timescale 1ns/10ps

`include "dense_settings.svh"

module tb_dense_layer import dense_pkg::*; ();

  localparam int clk_period      = 20;
  // vectors sent over all five tests
  localparam int total_vectors   = 54;
  localparam int watchdog_cycles = total_vectors * 20 + 400;

  logic         clk;
  logic         rst_n;
  logic         data_in_valid;
  feature_vec_t data_in;
  logic         data_in_ready;
  logic         data_out_valid;
  fixed_t       data_out;
  logic         data_out_ready;

  integer seed = 9736;
  int     error_count = 0;
  int     check_count = 0;
  int     results_seen = 0;
  int     test_start_errors;

  // scoreboard state
  fixed_t exp_q[$];
  fixed_t expected_out;
  fixed_t prev_data;
  logic   prev_stall;
  int     out_age;
  logic   check_wait = 1'b0;
  logic   bp_random = 1'b0;

  dense_layer_top u_dense_layer_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // ####################
  // reference and checks
  // ####################

  // dot product at full width then floor shift and keep the low word
  function automatic fixed_t dense_ref(input feature_vec_t v);
    longint acc;
    fixed_t f;
    acc = longint'(dense_bias) <<< `DENSE_FRAC_BITS;
    for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
      f   = v[i];
      acc = acc + longint'(f) * longint'(dense_weights[i]);
    end
    acc = acc >>> `DENSE_FRAC_BITS;
    return $signed(acc[`DENSE_DATA_WIDTH-1:0]);
  endfunction

  function automatic feature_vec_t random_vector();
    feature_vec_t v;
    integer r;
    for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
      r    = $random(seed);
      v[i] = r[`DENSE_DATA_WIDTH-1:0];
    end
    return v;
  endfunction

  task automatic check_fixed(input string name, input fixed_t actual, input fixed_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  // scoreboard pops on output transfer and pushes on input transfer
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_q.delete();
      prev_stall = 1'b0;
      out_age    = 1000;
    end else begin
      // stalled result must still be there unchanged
      if (prev_stall) begin
        check_bit("data_out_valid", data_out_valid, 1'b1);
        check_fixed("data_out", data_out, prev_data);
      end
      if (check_wait) begin
        check_bit("data_in_ready", data_in_ready, out_age > `DENSE_OUTPUT_WAIT_CYCLES);
      end
      if (data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("an output result arrived with no vector left to match at %0t", $time);
        end else begin
          expected_out = exp_q.pop_front();
          check_fixed("data_out", data_out, expected_out);
          results_seen++;
        end
      end
      if (data_in_valid && data_in_ready) begin
        exp_q.push_back(dense_ref(data_in));
      end
      prev_stall = data_out_valid && !data_out_ready;
      prev_data  = data_out;
      // edges since the last output transfer
      if (data_out_valid && data_out_ready) begin
        out_age = 1;
      end else if (out_age < 1000) begin
        out_age = out_age + 1;
      end
    end
  end

  // ####################
  // stimulus helpers
  // ####################

  // step to the falling edge and set data_out_ready
  task automatic next_cycle();
    integer r;
    @(negedge clk);
    if (bp_random) begin
      r              = $random(seed);
      data_out_ready = r[0];
    end else begin
      data_out_ready = 1'b1;
    end
  endtask

  // returns on the falling edge after the accepting edge with valid left high
  task automatic send_vector(input feature_vec_t v);
    data_in       = v;
    data_in_valid = 1'b1;
    @(posedge clk);
    while (!data_in_ready) begin
      next_cycle();
      @(posedge clk);
    end
    next_cycle();
  endtask

  task automatic drain_results();
    data_in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s, %0d errors", name,
             (error_count == test_start_errors) ? "ok" : "failed",
             error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // ####################
  // tests
  // ####################

  initial begin
    feature_vec_t v;
    rst_n          = 1'b0;
    data_in_valid  = 1'b0;
    data_in        = '0;
    data_out_ready = 1'b1;
    repeat (3) @(negedge clk);
    rst_n             = 1'b1;
    test_start_errors = 0;
    next_cycle();

    // four registers with the accepting edge counted as the first
    send_vector(random_vector());
    data_in_valid = 1'b0;
    for (int k = 1; k <= 4; k++) begin
      check_bit("data_out_valid", data_out_valid, k == 4);
      if (k < 4) begin
        next_cycle();
      end
    end
    drain_results();
    report_test("single result and latency");

    check_wait = 1'b1;
    for (int n = 0; n < 12; n++) begin
      send_vector(random_vector());
    end
    drain_results();
    check_wait = 1'b0;
    report_test("wait after output");

    bp_random = 1'b1;
    for (int n = 0; n < 30; n++) begin
      send_vector(random_vector());
    end
    drain_results();
    bp_random = 1'b0;
    next_cycle();
    report_test("random back-pressure");

    // extremes and alternating signs
    for (int n = 0; n < 4; n++) begin
      for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
        case (n)
          0:       v[i] = 16'sh7fff;
          1:       v[i] = 16'sh8000;
          2:       v[i] = (i % 2 == 0) ? 16'sh7fff : 16'sh8000;
          default: v[i] = (i % 2 == 0) ? 16'sh8000 : 16'sh7fff;
        endcase
      end
      send_vector(v);
      drain_results();
    end
    report_test("overflow wrap");

    // vectors still in the pipe when reset hits
    for (int n = 0; n < 4; n++) begin
      send_vector(random_vector());
    end
    data_in_valid = 1'b0;
    rst_n         = 1'b0;
    repeat (3) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    check_bit("data_out_valid", data_out_valid, 1'b0);
    check_bit("data_in_ready", data_in_ready, 1'b1);
    repeat (6) begin
      next_cycle();
      check_bit("data_out_valid", data_out_valid, 1'b0);
    end
    for (int n = 0; n < 3; n++) begin
      send_vector(random_vector());
    end
    drain_results();
    report_test("reset mid-stream");

    $display("summary: 5 tests, %0d checks, %0d results, %0d errors",
             check_count, results_seen, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // hard stop if a handshake never completes
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/dense_pkg.sv
rtl/pipe_ctrl_if.sv
rtl/input_decode.sv
rtl/dense_execute.sv
rtl/result_stage.sv
rtl/dense_layer_top.sv
testbench/tb_dense_layer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dense_layer
FILELIST  := sim.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
